/* Bender.yml */
package:
  name: prbs_checker

sources:
  - files:
      - design/prbs_cfg_pkg.sv
      - design/prbs_stat_pkg.sv
      - design/prbs_generator.sv
      - design/prbs_checker_core.sv
      - design/prbs_align_fsm.sv
      - design/prbs_phase_timer.sv
      - design/prbs_error_accum.sv
      - design/prbs_checker_top.sv
  - target: test
    files:
      - test/prbs_checker_checker.sv
      - test/prbs_checker_tb.sv

/* design/prbs_align_fsm.sv */
`timescale 1ns/100ps

module prbs_align_fsm #(
    parameter int n_channels = prbs_cfg_pkg::channels_default,
    parameter int lock_len   = prbs_cfg_pkg::lock_len_default,
    parameter int window_len = prbs_cfg_pkg::window_len_default
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  logic                             match,
    input  logic                             expired,
    output logic [$clog2(n_channels)-1:0]    rx_shift,
    output logic                             load,
    output logic [$clog2(window_len+1)-1:0]  load_val,
    output logic                             acc_clear,
    output logic                             acc_en,
    output logic                             busy,
    output logic                             locked,
    output logic                             window_done,
    output logic                             sweep_fail
);
    import prbs_cfg_pkg::*;
    import prbs_stat_pkg::*;

    localparam int shift_width = $clog2(n_channels);
    localparam int timer_width = $clog2(window_len + 1);
    localparam logic [shift_width-1:0] last_shift = shift_width'(n_channels - 1);

    align_state_t           state;
    align_state_t           state_next;
    logic [shift_width-1:0] shift;
    logic [shift_width-1:0] shift_next;

    always_comb begin
        state_next = state;
        shift_next = shift;
        load       = 1'b0;
        load_val   = '0;
        acc_clear  = 1'b0;
        case (state)
            // start is only honoured when no sweep is running
            st_idle, st_done, st_fail: begin
                if (start) begin
                    state_next = st_settle;
                    shift_next = '0;
                    acc_clear  = 1'b1;
                    load       = 1'b1;
                    load_val   = timer_width'(settle_len);
                end
            end
            st_settle: begin
                if (expired) begin
                    state_next = st_test;
                    load       = 1'b1;
                    load_val   = timer_width'(lock_len);
                end
            end
            st_test: begin
                // any miss ends this shift, a full run of matches locks it
                if (!match) begin
                    if (shift != last_shift) begin
                        state_next = st_settle;
                        shift_next = shift + 1'b1;
                        load       = 1'b1;
                        load_val   = timer_width'(settle_len);
                    end else begin
                        state_next = st_fail;
                    end
                end else if (expired) begin
                    state_next = st_count;
                    load       = 1'b1;
                    load_val   = timer_width'(window_len);
                end
            end
            st_count: begin
                if (expired) begin
                    state_next = st_done;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            shift <= '0;
        end else begin
            state <= state_next;
            shift <= shift_next;
        end
    end

    assign rx_shift    = shift;
    assign acc_en      = (state == st_count);
    assign busy        = (state == st_settle) || (state == st_test) || (state == st_count);
    assign locked      = (state == st_count) || (state == st_done);
    assign window_done = (state == st_done);
    assign sweep_fail  = (state == st_fail);

endmodule

/* design/prbs_cfg_pkg.sv */
package prbs_cfg_pkg;

    // LFSR length of the PRBS7 sequence
    localparam int prbs_order_default = 7;

    // bit index of the second tap for x^7+x^6+1
    // feedback is state[order-1] xor state[prbs_tap]
    localparam int prbs_tap = 5;

    // number of parallel lanes in one received word
    localparam int channels_default = 16;

    // cycles for the core pipeline to flush after a shift change
    localparam int settle_len = 4;

    // consecutive full matches needed before the shift counts as locked
    localparam int lock_len_default = 8;

    // length of the error counting window in cycles
    localparam int window_len_default = 64;

    localparam int err_width_default = 8;

endpackage

/* design/prbs_checker_core.sv */
`timescale 1ns/100ps

module prbs_checker_core #(
    parameter int n_prbs     = prbs_cfg_pkg::prbs_order_default,
    parameter int n_channels = prbs_cfg_pkg::channels_default
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [n_prbs-1:0]             prbs_init_vals [n_channels],
    input  logic [n_channels-1:0]         rx_bits,
    input  logic [$clog2(n_channels)-1:0] rx_shift,
    output logic [$clog2(n_channels):0]   match_bits,
    output logic                          match
);
    localparam int match_width = $clog2(n_channels) + 1;

    // receive history, newest word and the one before it
    logic [n_channels-1:0] rx_new;
    logic [n_channels-1:0] rx_old;

    always_ff @(posedge clk) begin
        rx_new <= rx_bits;
        rx_old <= rx_new;
    end

    // one generator per lane, bit k of the expected word
    logic [n_channels-1:0] prbs_bits;

    for (genvar k = 0; k < n_channels; k++) begin : g_lane
        prbs_generator #(
            .n_prbs(n_prbs)
        ) u_gen (
            .clk     (clk),
            .rst     (rst),
            .init_val(prbs_init_vals[k]),
            .out_bit (prbs_bits[k])
        );
    end

    // window of n_channels bits, top bit rx_shift below the top of the pair
    logic [2*n_channels-1:0] rx_concat;
    logic [n_channels-1:0]   rx_select_imm;
    logic [n_channels-1:0]   rx_select;

    assign rx_concat = {rx_new, rx_old};
    assign rx_select_imm = rx_concat[(2*n_channels-1-rx_shift) -: n_channels];

    always_ff @(posedge clk) begin
        rx_select <= rx_select_imm;
    end

    // per-bit agreement with the generator word
    logic [n_channels-1:0]  agree;
    logic [match_width-1:0] match_bits_imm;
    logic                   match_imm;

    assign agree = rx_select ~^ prbs_bits;

    always_comb begin
        match_bits_imm = '0;
        for (int i = 0; i < n_channels; i++) begin
            match_bits_imm = match_bits_imm + match_width'(agree[i]);
        end
    end

    assign match_imm = (rx_select == prbs_bits);

    always_ff @(posedge clk) begin
        if (rst) begin
            match_bits <= '0;
            match      <= 1'b0;
        end else begin
            match_bits <= match_bits_imm;
            match      <= match_imm;
        end
    end

endmodule

/* design/prbs_checker_top.sv */
`timescale 1ns/100ps

module prbs_checker_top #(
    parameter int n_prbs     = prbs_cfg_pkg::prbs_order_default,
    parameter int n_channels = prbs_cfg_pkg::channels_default,
    parameter int lock_len   = prbs_cfg_pkg::lock_len_default,
    parameter int window_len = prbs_cfg_pkg::window_len_default,
    parameter int err_width  = prbs_cfg_pkg::err_width_default
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [n_prbs-1:0]          prbs_init_vals [n_channels],
    input  logic [n_channels-1:0]      rx_bits,
    output prbs_stat_pkg::prbs_status_t status
);
    localparam int shift_width = $clog2(n_channels);
    localparam int match_width = $clog2(n_channels) + 1;
    localparam int timer_width = $clog2(window_len + 1);

    logic [shift_width-1:0] rx_shift;
    logic [match_width-1:0] match_bits;
    logic                   match;
    logic                   load;
    logic [timer_width-1:0] load_val;
    logic                   expired;
    logic                   acc_clear;
    logic                   acc_en;
    logic                   busy;
    logic                   locked;
    logic                   window_done;
    logic                   sweep_fail;
    logic [err_width-1:0]   err_count;

    prbs_checker_core #(
        .n_prbs    (n_prbs),
        .n_channels(n_channels)
    ) u_core (
        .clk           (clk),
        .rst           (rst),
        .prbs_init_vals(prbs_init_vals),
        .rx_bits       (rx_bits),
        .rx_shift      (rx_shift),
        .match_bits    (match_bits),
        .match         (match)
    );

    prbs_align_fsm #(
        .n_channels(n_channels),
        .lock_len  (lock_len),
        .window_len(window_len)
    ) u_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .match      (match),
        .expired    (expired),
        .rx_shift   (rx_shift),
        .load       (load),
        .load_val   (load_val),
        .acc_clear  (acc_clear),
        .acc_en     (acc_en),
        .busy       (busy),
        .locked     (locked),
        .window_done(window_done),
        .sweep_fail (sweep_fail)
    );

    prbs_phase_timer #(
        .width(timer_width)
    ) u_timer (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .load_val(load_val),
        .expired (expired)
    );

    prbs_error_accum #(
        .n_channels(n_channels),
        .err_width (err_width)
    ) u_accum (
        .clk       (clk),
        .rst       (rst),
        .clear     (acc_clear),
        .en        (acc_en),
        .match_bits(match_bits),
        .err_count (err_count)
    );

    always_comb begin
        status.busy        = busy;
        status.locked      = locked;
        status.window_done = window_done;
        status.sweep_fail  = sweep_fail;
        status.shift       = rx_shift;
        status.err_count   = err_count;
    end

endmodule

/* design/prbs_error_accum.sv */
`timescale 1ns/100ps

module prbs_error_accum #(
    parameter int n_channels = prbs_cfg_pkg::channels_default,
    parameter int err_width  = prbs_cfg_pkg::err_width_default
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  logic                        en,
    input  logic [$clog2(n_channels):0] match_bits,
    output logic [err_width-1:0]        err_count
);
    localparam int match_width = $clog2(n_channels) + 1;
    localparam int sum_width = ((err_width > match_width) ? err_width : match_width) + 1;
    localparam logic [sum_width-1:0] err_max = {err_width{1'b1}};

    logic [match_width-1:0] mismatch;
    logic [sum_width-1:0]   sum;

    // bits that disagreed in this word
    assign mismatch = match_width'(n_channels) - match_bits;
    assign sum = sum_width'(err_count) + sum_width'(mismatch);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            err_count <= '0;
        end else if (en) begin
            // sticks at all ones once the count overflows
            err_count <= (sum > err_max) ? '1 : sum[err_width-1:0];
        end
    end

endmodule

/* design/prbs_generator.sv */
`timescale 1ns/100ps

module prbs_generator #(
    parameter int n_prbs = prbs_cfg_pkg::prbs_order_default
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [n_prbs-1:0] init_val,
    output logic              out_bit
);
    import prbs_cfg_pkg::*;

    logic [n_prbs-1:0] state;
    logic              feedback;

    // fibonacci form, top bit xor tap bit shifted in at the bottom
    assign feedback = state[n_prbs-1] ^ state[prbs_tap];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= init_val;
        end else begin
            state <= {state[n_prbs-2:0], feedback};
        end
    end

    // the lane bit is the top of the state register
    assign out_bit = state[n_prbs-1];

endmodule

/* design/prbs_phase_timer.sv */
`timescale 1ns/100ps

module prbs_phase_timer #(
    parameter int width = 7
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  logic [width-1:0] load_val,
    output logic             expired
);
    logic [width-1:0] cnt;

    // expired is high for the one cycle in which cnt holds one
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            expired <= 1'b0;
        end else if (load) begin
            cnt     <= load_val;
            expired <= (load_val == width'(1));
        end else if (cnt != '0) begin
            cnt     <= cnt - 1'b1;
            expired <= (cnt == width'(2));
        end else begin
            // parked at zero
            expired <= 1'b0;
        end
    end

endmodule

/* design/prbs_stat_pkg.sv */
package prbs_stat_pkg;

    localparam int stat_shift_width = $clog2(prbs_cfg_pkg::channels_default);
    localparam int stat_err_width = prbs_cfg_pkg::err_width_default;

    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_settle = 3'd1,
        st_test   = 3'd2,
        st_count  = 3'd3,
        st_done   = 3'd4,
        st_fail   = 3'd5
    } align_state_t;

    // levels seen from outside, all decoded from the alignment state
    typedef struct packed {
        logic                        busy;
        logic                        locked;
        logic                        window_done;
        logic                        sweep_fail;
        logic [stat_shift_width-1:0] shift;
        logic [stat_err_width-1:0]   err_count;
    } prbs_status_t;

endpackage

/* prbs_checker.f */
design/prbs_cfg_pkg.sv
design/prbs_stat_pkg.sv
design/prbs_generator.sv
design/prbs_checker_core.sv
design/prbs_align_fsm.sv
design/prbs_phase_timer.sv
design/prbs_error_accum.sv
design/prbs_checker_top.sv
test/prbs_checker_checker.sv
test/prbs_checker_tb.sv

/* test/prbs_checker_checker.sv */
`timescale 1ns/100ps

module prbs_checker_checker (
    input logic                        clk,
    input logic                        rst,
    input logic                        start,
    input prbs_stat_pkg::prbs_status_t status
);
    int unsigned assert_fails = 0;

    // a sweep ends either locked or failed
    a_lock_or_fail: assert property (@(posedge clk) disable iff (rst)
        !(status.locked && status.sweep_fail))
        else begin
            assert_fails++;
            $error("locked and sweep_fail are high together");
        end

    a_done_idle: assert property (@(posedge clk) disable iff (rst)
        !(status.window_done && status.busy))
        else begin
            assert_fails++;
            $error("window_done is high while busy");
        end

    // the count only drops on the clear that an accepted start causes
    a_count_rises: assert property (@(posedge clk) disable iff (rst)
        (status.err_count < $past(status.err_count)) |-> $past(start))
        else begin
            assert_fails++;
            $error("err_count decreased without a start pulse");
        end

endmodule

/* test/prbs_checker_tb.sv */
`timescale 1ns/100ps

module prbs_checker_tb;
    import prbs_cfg_pkg::*;
    import prbs_stat_pkg::*;

    localparam int n_prbs = prbs_order_default;
    localparam int n_channels = channels_default;
    localparam int prbs_period = (1 << n_prbs) - 1;
    localparam int err_max = (1 << err_width_default) - 1;
    localparam int clk_period = 40;
    localparam int margin_cycles = 60;
    localparam int n_rows = 9;
    localparam int watchdog_cycles =
        n_rows * (n_channels * (settle_len + lock_len_default) + window_len_default
        + margin_cycles);

    typedef struct packed {
        logic [4:0] delay;
        logic [7:0] flips;
        logic       invert;
        logic       zeros;
        logic       expect_fail;
    } row_t;

    // delay in bits, bits or words to corrupt, invert words, all-zero words, sweep fails
    localparam row_t rows [n_rows] = '{
        '{5'd16, 8'd0,  1'b0, 1'b0, 1'b0},
        '{5'd13, 8'd0,  1'b0, 1'b0, 1'b0},
        '{5'd1,  8'd0,  1'b0, 1'b0, 1'b0},
        '{5'd9,  8'd5,  1'b0, 1'b0, 1'b0},
        '{5'd6,  8'd0,  1'b0, 1'b0, 1'b0},
        '{5'd11, 8'd20, 1'b0, 1'b0, 1'b0},
        '{5'd4,  8'd30, 1'b1, 1'b0, 1'b0},
        '{5'd16, 8'd0,  1'b0, 1'b1, 1'b1},
        '{5'd7,  8'd3,  1'b0, 1'b0, 1'b0}
    };

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic                  start = 1'b0;
    logic [n_prbs-1:0]     seeds [n_channels];
    logic [n_channels-1:0] rx_bits = '0;
    prbs_status_t          status;

    // one period of the expected generator words, index = steps since reset
    logic [n_channels-1:0] gen_words [prbs_period];

    int     cur_delay = n_channels;
    bit     zero_mode = 1'b0;
    bit     invert_mode = 1'b0;
    int     flip_from = 0;
    int     flip_len = 0;
    int     tx_pos = 0;
    int     check_count = 0;
    int     fail_count = 0;
    integer seed = 39;

    prbs_checker_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .prbs_init_vals(seeds),
        .rx_bits       (rx_bits),
        .status        (status)
    );

    bind prbs_checker_top prbs_checker_checker u_checker (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .status(status)
    );

    initial begin : clock_gen
        forever #(clk_period / 2) clk = ~clk;
    end

    // x^7+x^6+1 per lane, lane bit is the top of the state
    function automatic void build_words();
        logic [n_prbs-1:0] st;
        for (int k = 0; k < n_channels; k++) begin
            st = seeds[k];
            for (int j = 0; j < prbs_period; j++) begin
                gen_words[j][k] = st[n_prbs-1];
                st = {st[n_prbs-2:0], st[n_prbs-1] ^ st[prbs_tap]};
            end
        end
    endfunction

    // word driven at cycle t, lsb first serial stream delayed by d bits
    // tx word x carries generator word x+3 so that delay n_channels lands on shift zero
    function automatic logic [n_channels-1:0] stream_word(input int t, input int d,
                                                          input bit zero);
        logic [n_channels-1:0] w;
        int                    q;
        w = '0;
        if (!zero) begin
            for (int i = 0; i < n_channels; i++) begin
                q = t * n_channels + i - d + n_channels * prbs_period * 4;
                w[i] = gen_words[(q / n_channels + 3) % prbs_period][q % n_channels];
            end
        end
        return w;
    endfunction

    // window whose top bit sits s bits below the top of {newer, older}
    function automatic logic [n_channels-1:0] select_window(input logic [n_channels-1:0] newer,
                                                            input logic [n_channels-1:0] older,
                                                            input int s);
        logic [2*n_channels-1:0] pair;
        pair = {newer, older};
        pair = pair >> (n_channels - s);
        return pair[n_channels-1:0];
    endfunction

    // words sampled at edges k-1 and k-2 meet generator word k+1
    function automatic int lowest_shift(input int d, input bit zero);
        bit ok;
        for (int s = 0; s < n_channels; s++) begin
            ok = 1'b1;
            for (int k = 2; k < 2 + prbs_period; k++) begin
                if (select_window(stream_word(k - 1, d, zero), stream_word(k - 2, d, zero), s)
                        != gen_words[(k + 1) % prbs_period]) begin
                    ok = 1'b0;
                end
            end
            if (ok) begin
                return s;
            end
        end
        return n_channels;
    endfunction

    function automatic int expected_errors(input int flips, input bit invert);
        int total;
        total = invert ? flips * n_channels : flips;
        if (total > err_max) begin
            total = err_max;
        end
        return total;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        check_count++;
        assert (got == want) else begin
            fail_count++;
            $display("FAILED %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        check_count++;
        assert (cond) else begin
            fail_count++;
            $display("error: %s", what);
        end
    endtask

    // receive word source, bit 0 flips or whole-word inversion inside the flip range
    always @(posedge clk) begin : drive_rx
        logic [n_channels-1:0] word;
        int                    pos;
        pos = rst ? 0 : tx_pos;
        word = stream_word(pos, cur_delay, zero_mode);
        if (pos >= flip_from && pos < flip_from + flip_len) begin
            word = invert_mode ? ~word : word ^ n_channels'(1);
        end
        rx_bits <= word;
        tx_pos <= pos + 1;
    end

    initial begin : main
        row_t row;
        int   want_shift;
        int   want_err;
        int   fails_before;
        int   fail_total;
        for (int k = 0; k < n_channels; k++) begin
            seeds[k] = n_prbs'($random(seed));
            if (seeds[k] == '0) begin
                seeds[k] = 1;
            end
        end
        build_words();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        check_value("status", status, 32'h0);
        $display("reset: %s", (fail_count == 0) ? "ok" : "mismatch");

        for (int r = 0; r < n_rows; r++) begin
            row = rows[r];
            fails_before = fail_count;
            want_shift = lowest_shift(row.delay, row.zeros);
            want_err = expected_errors(row.flips, row.invert);
            check_true((want_shift == n_channels) == row.expect_fail,
                       "reference model and table disagree on whether the row locks");
            @(posedge clk);
            cur_delay <= row.delay;
            zero_mode <= row.zeros;
            invert_mode <= row.invert;
            flip_len <= 0;
            repeat (settle_len) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            @(posedge clk);
            check_true(status.busy, "sweep did not start after the start pulse");
            check_value("err_count", status.err_count, 32'h0);
            if (!row.expect_fail) begin
                while (!status.locked && !status.sweep_fail) @(posedge clk);
                repeat (4) @(posedge clk);
                if (status.locked) begin
                    // corrupt inside the window, and a start that must be ignored
                    flip_from <= tx_pos + 1;
                    flip_len <= row.flips;
                    start <= 1'b1;
                    @(posedge clk);
                    start <= 1'b0;
                end
            end
            while (!status.window_done && !status.sweep_fail) @(posedge clk);
            if (row.expect_fail) begin
                check_value("sweep_fail", status.sweep_fail, 32'h1);
                check_value("locked", status.locked, 32'h0);
                check_value("shift", status.shift, n_channels - 1);
            end else begin
                check_value("window_done", status.window_done, 32'h1);
                check_value("locked", status.locked, 32'h1);
                check_value("shift", status.shift, want_shift);
            end
            check_value("err_count", status.err_count, want_err);
            $display("row %0d delay %0d flips %0d invert %0d zeros %0d: %s", r, row.delay,
                     row.flips, row.invert, row.zeros,
                     (fail_count == fails_before) ? "ok" : "mismatch");
        end

        fail_total = fail_count + dut0.u_checker.assert_fails;
        $display("%0d checks, %0d mismatches, %0d assertion errors", check_count, fail_count,
                 dut0.u_checker.assert_fails);
        if (fail_total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        $display("timeout after %0d clock periods, the rows did not finish", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
